// ==== sources.f ====
logic/chi_pkg.sv
logic/chi_flit_if.sv
logic/chi_rn_port.sv
logic/chi_req_arbiter.sv
logic/chi_rsp_router.sv
logic/chi_xbar_top.sv
tb/tb_clkgen.sv
tb/tb_chi_xbar.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_chi_xbar -o sim_chi_xbar
./obj_dir/sim_chi_xbar > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== tb/tb_chi_xbar.sv ====
`timescale 1ns/1ps

module tb_chi_xbar;

  localparam int REQ_DEPTH = 4;
  localparam int RSP_DEPTH = 4;
  // 1 + 32 + 16 + 16 + 8 requests over all tests
  localparam int TOTAL_REQ = 73;
  localparam int CYCLE_LIMIT = 20 * TOTAL_REQ + 200;
  localparam int SN_WINDOW = 4;
  localparam int RN_RSP_WINDOW = 4;

  logic clk;
  logic rst;

  // DUT inputs, all start low
  logic               linkreq [2] = '{1'b0, 1'b0};
  logic               rn_pend [2] = '{1'b0, 1'b0};
  logic               rn_flitv [2] = '{1'b0, 1'b0};
  chi_pkg::req_flit_t rn_flit [2] = '{'0, '0};
  logic               rn_rsp_lcrdv [2] = '{1'b0, 1'b0};
  logic               sn_req_lcrdv = 1'b0;
  logic               sn_rsp_pend = 1'b0;
  logic               sn_rsp_flitv = 1'b0;
  chi_pkg::rsp_flit_t sn_rsp_flit = '0;

  // DUT outputs
  logic               linkack [2];
  logic               rn_req_lcrdv [2];
  logic               rn_rsp_pend [2];
  logic               rn_rsp_flitv [2];
  chi_pkg::rsp_flit_t rn_rsp_flit [2];
  logic               sn_req_pend;
  logic               sn_req_flitv;
  chi_pkg::req_flit_t sn_req_flit;
  logic               sn_rsp_lcrdv;

  // --------------------
  // Model state
  // --------------------
  chi_pkg::req_flit_t req_q [2][$];
  chi_pkg::req_flit_t exp_req_q [2][$];
  chi_pkg::rsp_flit_t exp_rsp_q [2][$];
  chi_pkg::rsp_flit_t sn_rsp_q [$];
  int rn_req_crd [2] = '{0, 0};
  int rn_rsp_out [2] = '{0, 0};
  bit rsp_hold [2] = '{1'b0, 1'b0};
  int sent [2] = '{0, 0};
  int arrived [2] = '{0, 0};
  int rcv [2] = '{0, 0};
  int prev_snap [2] = '{0, 0};
  int sn_granted = 0;
  int sn_arrived = 0;
  int sn_cap = 1000000;
  int sn_rsp_crd = 0;
  int last_src = -1;
  int cycles = 0;
  bit quiet_chk = 1'b1;
  // Wanted link request level, driven by the RN models
  bit link_on = 1'b0;
  // Link request was driven low on the previous falling edge
  bit link_low [2] = '{1'b1, 1'b1};
  logic sn_pend_prev = 1'b0;
  logic rsp_pend_prev [2] = '{1'b0, 1'b0};
  int checks = 0;
  int errors = 0;
  int seed = 32'ha0d0;

  tb_clkgen i_clkgen (.clk(clk), .rst(rst));

  chi_xbar_top #(
    .REQ_DEPTH (REQ_DEPTH),
    .RSP_DEPTH (RSP_DEPTH)
  ) i_chi_xbar_top (
    .clk                 (clk),
    .rst                 (rst),
    .rn0_txlinkactivereq (linkreq[0]),
    .rn0_txlinkactiveack (linkack[0]),
    .rn0_txreqflitpend   (rn_pend[0]),
    .rn0_txreqflitv      (rn_flitv[0]),
    .rn0_txreqflit       (rn_flit[0]),
    .rn0_txreqlcrdv      (rn_req_lcrdv[0]),
    .rn0_rxrspflitpend   (rn_rsp_pend[0]),
    .rn0_rxrspflitv      (rn_rsp_flitv[0]),
    .rn0_rxrspflit       (rn_rsp_flit[0]),
    .rn0_rxrsplcrdv      (rn_rsp_lcrdv[0]),
    .rn1_txlinkactivereq (linkreq[1]),
    .rn1_txlinkactiveack (linkack[1]),
    .rn1_txreqflitpend   (rn_pend[1]),
    .rn1_txreqflitv      (rn_flitv[1]),
    .rn1_txreqflit       (rn_flit[1]),
    .rn1_txreqlcrdv      (rn_req_lcrdv[1]),
    .rn1_rxrspflitpend   (rn_rsp_pend[1]),
    .rn1_rxrspflitv      (rn_rsp_flitv[1]),
    .rn1_rxrspflit       (rn_rsp_flit[1]),
    .rn1_rxrsplcrdv      (rn_rsp_lcrdv[1]),
    .sn_rxreqflitpend    (sn_req_pend),
    .sn_rxreqflitv       (sn_req_flitv),
    .sn_rxreqflit        (sn_req_flit),
    .sn_rxreqlcrdv       (sn_req_lcrdv),
    .sn_txrspflitpend    (sn_rsp_pend),
    .sn_txrspflitv       (sn_rsp_flitv),
    .sn_txrspflit        (sn_rsp_flit),
    .sn_txrsplcrdv       (sn_rsp_lcrdv)
  );

  // --------------------
  // Helpers
  // --------------------
  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic note_error(input string msg);
    checks++;
    errors++;
    $display("%s", msg);
  endtask

  // Response the SN owes for one request
  function automatic chi_pkg::rsp_flit_t expected_rsp(input chi_pkg::req_flit_t req);
    chi_pkg::node_id_t src;
    chi_pkg::txn_id_t  txn;
    chi_pkg::opcode_t  op;
    chi_pkg::addr_t    addr;
    src  = req[chi_pkg::REQ_SRCID_LSB +: chi_pkg::NODE_ID_W];
    txn  = req[chi_pkg::REQ_TXNID_LSB +: chi_pkg::TXN_ID_W];
    op   = req[chi_pkg::REQ_OPCODE_LSB +: chi_pkg::OPCODE_W];
    addr = req[chi_pkg::REQ_ADDR_LSB +: chi_pkg::ADDR_W];
    return {src, txn, chi_pkg::opcode_t'(op + 1'b1), addr[1:0] ^ op[1:0]};
  endfunction

  // Random fields, source id random too since the port overwrites it
  task automatic queue_random_reqs(input int rn, input int n);
    chi_pkg::req_flit_t f;
    for (int i = 0; i < n; i++) begin
      f = {chi_pkg::txn_id_t'($random(seed)), chi_pkg::node_id_t'($random(seed)),
           chi_pkg::opcode_t'($random(seed)), chi_pkg::addr_t'($random(seed))};
      req_q[rn].push_back(f);
    end
  endtask

  task automatic wait_drain();
    while (req_q[0].size() != 0 || req_q[1].size() != 0 ||
           exp_rsp_q[0].size() != 0 || exp_rsp_q[1].size() != 0 ||
           sn_rsp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("test %s finished, %0d errors", name, errors - err_start);
  endtask

  // --------------------
  // Run limit
  // --------------------
  always @(negedge clk) begin
    if (!rst) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

  // --------------------
  // RN and SN models
  // --------------------
  // Samples and drives on the falling edge, outputs settled since the rising edge
  always @(negedge clk) begin
    chi_pkg::req_flit_t f;
    chi_pkg::rsp_flit_t r;
    int src;
    // Reset included
    if (quiet_chk && (linkack[0] || linkack[1] || rn_req_lcrdv[0] || rn_req_lcrdv[1] ||
                      rn_rsp_flitv[0] || rn_rsp_flitv[1] || sn_req_flitv ||
                      sn_req_pend || rn_rsp_pend[0] || rn_rsp_pend[1])) begin
      note_error("activity seen before link activation");
    end
    if (!rst) begin
      // Link request, credits judged against the level driven a cycle earlier
      for (int n = 0; n < 2; n++) begin
        if (link_low[n] && rn_req_lcrdv[n]) begin
          note_error($sformatf("RN%0d request credit granted with link request low", n));
        end
        linkreq[n]  = link_on;
        link_low[n] = !link_on;
      end

      // Flitpend leads flitv by one cycle
      if (sn_req_flitv && !sn_pend_prev) begin
        note_error("SN request flitv without flitpend in the cycle before");
      end
      sn_pend_prev = sn_req_pend;

      // SN request arrivals
      if (sn_req_flitv) begin
        src = int'(sn_req_flit[chi_pkg::REQ_SRCID_LSB +: chi_pkg::NODE_ID_W]);
        sn_arrived++;
        if (sn_arrived > sn_granted) begin
          note_error("SN received a flit without a granted credit");
        end
        if (src > 1 || exp_req_q[src].size() == 0) begin
          note_error("SN received an unexpected request");
        end else begin
          arrived[src]++;
          check_val("sn_req_flit", exp_req_q[src].pop_front(), sn_req_flit);
          // Other port had a flit waiting when this one was granted
          if (src == last_src && prev_snap[1 - src] > 0) begin
            note_error("round-robin order broken at the SN");
          end
          last_src = src;
        end
        sn_rsp_q.push_back(expected_rsp(sn_req_flit));
      end
      for (int n = 0; n < 2; n++) begin
        prev_snap[n] = sent[n] - arrived[n];
      end

      // RN request senders, credits from earlier cycles only
      for (int n = 0; n < 2; n++) begin
        rn_flitv[n] = 1'b0;
        if (req_q[n].size() != 0 && rn_req_crd[n] > 0) begin
          f = req_q[n].pop_front();
          rn_flit[n]  = f;
          rn_flitv[n] = 1'b1;
          rn_req_crd[n]--;
          sent[n]++;
          f[chi_pkg::REQ_SRCID_LSB +: chi_pkg::NODE_ID_W] = chi_pkg::node_id_t'(n);
          exp_req_q[n].push_back(f);
          exp_rsp_q[n].push_back(expected_rsp(f));
        end
        if (rn_req_lcrdv[n]) begin
          rn_req_crd[n]++;
        end
        rn_pend[n] = (req_q[n].size() != 0);
      end

      // RN response receivers
      for (int n = 0; n < 2; n++) begin
        if (rn_rsp_flitv[n] && !rsp_pend_prev[n]) begin
          note_error($sformatf("RN%0d response flitv without flitpend in the cycle before", n));
        end
        rsp_pend_prev[n] = rn_rsp_pend[n];
        if (rn_rsp_flitv[n]) begin
          rcv[n]++;
          rn_rsp_out[n]--;
          if (exp_rsp_q[n].size() == 0) begin
            note_error($sformatf("RN%0d received a response it did not expect", n));
          end else begin
            check_val($sformatf("rn%0d_rsp", n), exp_rsp_q[n].pop_front(), rn_rsp_flit[n]);
          end
        end
        rn_rsp_lcrdv[n] = !rsp_hold[n] && (rn_rsp_out[n] < RN_RSP_WINDOW);
        if (rn_rsp_lcrdv[n]) begin
          rn_rsp_out[n]++;
        end
      end

      // SN credit grant and response sender
      sn_req_lcrdv = (sn_granted - sn_arrived < SN_WINDOW) && (sn_granted < sn_cap);
      if (sn_req_lcrdv) begin
        sn_granted++;
      end
      sn_rsp_flitv = 1'b0;
      if (sn_rsp_q.size() != 0 && sn_rsp_crd > 0) begin
        r = sn_rsp_q.pop_front();
        sn_rsp_flit  = r;
        sn_rsp_flitv = 1'b1;
        sn_rsp_crd--;
      end
      if (sn_rsp_lcrdv) begin
        sn_rsp_crd++;
      end
      sn_rsp_pend = (sn_rsp_q.size() != 0);
    end
  end

  // --------------------
  // Tests
  // --------------------
  initial begin
    int e0;
    int held;
    int rcv0;
    int rcv1;
    // Reset and link activation
    e0 = errors;
    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
    quiet_chk = 1'b0;
    link_on = 1'b1;
    while (!(linkack[0] && linkack[1])) begin
      @(negedge clk);
    end
    repeat (REQ_DEPTH + 6) @(negedge clk);
    check_val("rn0_req_credits", REQ_DEPTH, rn_req_crd[0]);
    check_val("rn1_req_credits", REQ_DEPTH, rn_req_crd[1]);
    report_test("reset_link", e0);

    // Single request from RN0
    e0 = errors;
    rcv1 = rcv[1];
    queue_random_reqs(0, 1);
    wait_drain();
    check_val("single_rsp_count", 1, rcv[0]);
    check_val("single_rn1_count", rcv1, rcv[1]);
    report_test("single_request", e0);

    // Both RNs at once
    e0 = errors;
    queue_random_reqs(0, 16);
    queue_random_reqs(1, 16);
    wait_drain();
    check_val("concurrent_rsp_count", 33, rcv[0] + rcv[1] - 0);
    report_test("concurrent", e0);

    // SN stops granting after two more credits
    e0 = errors;
    sn_cap = sn_granted + 2;
    queue_random_reqs(0, 8);
    queue_random_reqs(1, 8);
    repeat (60) @(negedge clk);
    check_val("sn_bp_stalled", sn_granted, sn_arrived);
    if (sn_arrived >= 33 + 16) begin
      note_error("SN back-pressure did not stall the requests");
    end
    sn_cap = 1000000;
    wait_drain();
    report_test("sn_backpressure", e0);

    // RN1 withholds response credits
    e0 = errors;
    rsp_hold[1] = 1'b1;
    held = rn_rsp_out[1];
    rcv0 = rcv[0];
    rcv1 = rcv[1];
    queue_random_reqs(1, 8);
    queue_random_reqs(0, 8);
    repeat (80) @(negedge clk);
    if (rcv[1] - rcv1 > held) begin
      note_error("RN1 received more responses than its credits allowed");
    end
    if (rcv[0] == rcv0) begin
      note_error("RN0 responses blocked by RN1 back-pressure");
    end
    rsp_hold[1] = 1'b0;
    wait_drain();

    // Deactivation with flits still buffered behind a stalled SN
    sn_cap = sn_granted;
    queue_random_reqs(0, REQ_DEPTH);
    queue_random_reqs(1, REQ_DEPTH);
    while (req_q[0].size() != 0 || req_q[1].size() != 0) begin
      @(negedge clk);
    end
    link_on = 1'b0;
    repeat (10) @(negedge clk);
    // Ack held only while the port buffer is not empty
    for (int n = 0; n < 2; n++) begin
      check_val($sformatf("rn%0d_ack_buffered", n), sent[n] != arrived[n], linkack[n]);
    end
    // Buffers drain, freed slots must not turn into credits
    sn_cap = 1000000;
    while (linkack[0] || linkack[1]) begin
      @(negedge clk);
    end
    wait_drain();
    repeat (10) @(negedge clk);
    report_test("rn_backpressure_deactivate", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Held for five rising edges, released on the fifth
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== logic/chi_xbar_top.sv ====
`timescale 1ns/1ps

module chi_xbar_top #(
  parameter int REQ_DEPTH = 4,
  parameter int RSP_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst,
  // RN0
  input  logic               rn0_txlinkactivereq,
  output logic               rn0_txlinkactiveack,
  input  logic               rn0_txreqflitpend,
  input  logic               rn0_txreqflitv,
  input  chi_pkg::req_flit_t rn0_txreqflit,
  output logic               rn0_txreqlcrdv,
  output logic               rn0_rxrspflitpend,
  output logic               rn0_rxrspflitv,
  output chi_pkg::rsp_flit_t rn0_rxrspflit,
  input  logic               rn0_rxrsplcrdv,
  // RN1
  input  logic               rn1_txlinkactivereq,
  output logic               rn1_txlinkactiveack,
  input  logic               rn1_txreqflitpend,
  input  logic               rn1_txreqflitv,
  input  chi_pkg::req_flit_t rn1_txreqflit,
  output logic               rn1_txreqlcrdv,
  output logic               rn1_rxrspflitpend,
  output logic               rn1_rxrspflitv,
  output chi_pkg::rsp_flit_t rn1_rxrspflit,
  input  logic               rn1_rxrsplcrdv,
  // SN request, link always running
  output logic               sn_rxreqflitpend,
  output logic               sn_rxreqflitv,
  output chi_pkg::req_flit_t sn_rxreqflit,
  input  logic               sn_rxreqlcrdv,
  // SN response
  input  logic               sn_txrspflitpend,
  input  logic               sn_txrspflitv,
  input  chi_pkg::rsp_flit_t sn_txrspflit,
  output logic               sn_txrsplcrdv
);

  localparam int NUM_RN = 2;

  chi_flit_if #(.FLIT_W(chi_pkg::REQ_FLIT_W)) rn0_req_if ();
  chi_flit_if #(.FLIT_W(chi_pkg::REQ_FLIT_W)) rn1_req_if ();
  chi_flit_if #(.FLIT_W(chi_pkg::RSP_FLIT_W)) rn0_rsp_if ();
  chi_flit_if #(.FLIT_W(chi_pkg::RSP_FLIT_W)) rn1_rsp_if ();
  chi_flit_if #(.FLIT_W(chi_pkg::REQ_FLIT_W)) sn_req_if ();
  chi_flit_if #(.FLIT_W(chi_pkg::RSP_FLIT_W)) sn_rsp_if ();

  // Port to arbiter
  chi_pkg::req_flit_t port_req_flit [NUM_RN];
  logic [NUM_RN-1:0]  port_req_valid;
  logic [NUM_RN-1:0]  port_req_ready;
  // Router to ports, flit shared
  chi_pkg::rsp_flit_t route_rsp_flit;
  logic [NUM_RN-1:0]  route_rsp_valid;
  logic [NUM_RN-1:0]  route_rsp_ready;

  // --------------------
  // Pins to channels
  // --------------------
  assign rn0_req_if.flitpend = rn0_txreqflitpend;
  assign rn0_req_if.flitv    = rn0_txreqflitv;
  assign rn0_req_if.flit     = rn0_txreqflit;
  assign rn0_txreqlcrdv      = rn0_req_if.lcrdv;
  assign rn0_rxrspflitpend   = rn0_rsp_if.flitpend;
  assign rn0_rxrspflitv      = rn0_rsp_if.flitv;
  assign rn0_rxrspflit       = rn0_rsp_if.flit;
  assign rn0_rsp_if.lcrdv    = rn0_rxrsplcrdv;

  assign rn1_req_if.flitpend = rn1_txreqflitpend;
  assign rn1_req_if.flitv    = rn1_txreqflitv;
  assign rn1_req_if.flit     = rn1_txreqflit;
  assign rn1_txreqlcrdv      = rn1_req_if.lcrdv;
  assign rn1_rxrspflitpend   = rn1_rsp_if.flitpend;
  assign rn1_rxrspflitv      = rn1_rsp_if.flitv;
  assign rn1_rxrspflit       = rn1_rsp_if.flit;
  assign rn1_rsp_if.lcrdv    = rn1_rxrsplcrdv;

  assign sn_rxreqflitpend    = sn_req_if.flitpend;
  assign sn_rxreqflitv       = sn_req_if.flitv;
  assign sn_rxreqflit        = sn_req_if.flit;
  assign sn_req_if.lcrdv     = sn_rxreqlcrdv;
  assign sn_rsp_if.flitpend  = sn_txrspflitpend;
  assign sn_rsp_if.flitv     = sn_txrspflitv;
  assign sn_rsp_if.flit      = sn_txrspflit;
  assign sn_txrsplcrdv       = sn_rsp_if.lcrdv;

  // --------------------
  // Blocks
  // --------------------
  chi_rn_port #(
    .REQ_DEPTH (REQ_DEPTH),
    .PORT_ID   (chi_pkg::node_id_t'(0))
  ) i_rn_port0 (
    .clk             (clk),
    .rst             (rst),
    .req_in          (rn0_req_if),
    .rsp_out         (rn0_rsp_if),
    .txlinkactivereq (rn0_txlinkactivereq),
    .txlinkactiveack (rn0_txlinkactiveack),
    .req_flit        (port_req_flit[0]),
    .req_valid       (port_req_valid[0]),
    .req_ready       (port_req_ready[0]),
    .rsp_flit        (route_rsp_flit),
    .rsp_valid       (route_rsp_valid[0]),
    .rsp_ready       (route_rsp_ready[0])
  );

  chi_rn_port #(
    .REQ_DEPTH (REQ_DEPTH),
    .PORT_ID   (chi_pkg::node_id_t'(1))
  ) i_rn_port1 (
    .clk             (clk),
    .rst             (rst),
    .req_in          (rn1_req_if),
    .rsp_out         (rn1_rsp_if),
    .txlinkactivereq (rn1_txlinkactivereq),
    .txlinkactiveack (rn1_txlinkactiveack),
    .req_flit        (port_req_flit[1]),
    .req_valid       (port_req_valid[1]),
    .req_ready       (port_req_ready[1]),
    .rsp_flit        (route_rsp_flit),
    .rsp_valid       (route_rsp_valid[1]),
    .rsp_ready       (route_rsp_ready[1])
  );

  chi_req_arbiter #(
    .NUM_RN (NUM_RN)
  ) i_req_arbiter (
    .clk       (clk),
    .rst       (rst),
    .req_flit  (port_req_flit),
    .req_valid (port_req_valid),
    .req_ready (port_req_ready),
    .sn_req    (sn_req_if)
  );

  chi_rsp_router #(
    .RSP_DEPTH (RSP_DEPTH),
    .NUM_RN    (NUM_RN)
  ) i_rsp_router (
    .clk       (clk),
    .rst       (rst),
    .sn_rsp    (sn_rsp_if),
    .rsp_flit  (route_rsp_flit),
    .rsp_valid (route_rsp_valid),
    .rsp_ready (route_rsp_ready)
  );

endmodule

// ==== logic/chi_rsp_router.sv ====
`timescale 1ns/1ps

module chi_rsp_router #(
  parameter int RSP_DEPTH = 4,
  parameter int NUM_RN    = 2
) (
  input  logic               clk,
  input  logic               rst,
  chi_flit_if.rx             sn_rsp,
  output chi_pkg::rsp_flit_t rsp_flit,
  output logic [NUM_RN-1:0]  rsp_valid,
  input  logic [NUM_RN-1:0]  rsp_ready
);

  localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
  localparam int CNT_W = $clog2(RSP_DEPTH + 1);

  chi_pkg::rsp_flit_t rsp_mem [RSP_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   rsp_cnt;
  logic [CNT_W-1:0]   cnt_n;
  // Credits sitting at the SN
  logic [CNT_W-1:0]   crd_out;
  logic [CNT_W-1:0]   crd_n;
  logic               lcrdv_q;
  logic               push;
  logic               pop;
  chi_pkg::node_id_t  head_tgt;
  chi_pkg::node_id_t  in_tgt;

  assign push = sn_rsp.flitv;
  assign pop  = |(rsp_valid & rsp_ready);

  // --------------------
  // Credit grant
  // --------------------
  // Next-cycle occupancy and outstanding credits
  assign cnt_n = rsp_cnt + CNT_W'(push) - CNT_W'(pop);
  assign crd_n = crd_out + CNT_W'(lcrdv_q) - CNT_W'(push);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      rsp_cnt <= '0;
      crd_out <= '0;
      lcrdv_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      rsp_cnt <= cnt_n;
      crd_out <= crd_n;
      // One credit per slot not yet promised
      lcrdv_q <= (int'(crd_n) + int'(cnt_n)) < RSP_DEPTH;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      rsp_mem[wr_ptr] <= sn_rsp.flit;
    end
  end

  assign sn_rsp.lcrdv = lcrdv_q;

  // --------------------
  // Routing by target id
  // --------------------
  assign rsp_flit = rsp_mem[rd_ptr];
  assign head_tgt = rsp_flit[chi_pkg::RSP_TGTID_LSB +: chi_pkg::NODE_ID_W];

  // Head offered to its own port only
  always_comb begin
    for (int i = 0; i < NUM_RN; i++) begin
      rsp_valid[i] = (rsp_cnt != '0) && (head_tgt == chi_pkg::node_id_t'(i));
    end
  end

  assign in_tgt = sn_rsp.flit[chi_pkg::RSP_TGTID_LSB +: chi_pkg::NODE_ID_W];

  // SN answers only to existing RNs
  a_tgt_range: assert property (@(posedge clk) disable iff (rst)
    sn_rsp.flitv |-> (int'(in_tgt) < NUM_RN));

endmodule

// ==== logic/chi_req_arbiter.sv ====
`timescale 1ns/1ps

module chi_req_arbiter #(
  parameter int NUM_RN = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  chi_pkg::req_flit_t req_flit [NUM_RN],
  input  logic [NUM_RN-1:0]  req_valid,
  output logic [NUM_RN-1:0]  req_ready,
  chi_flit_if.tx             sn_req
);

  localparam int IDX_W = (NUM_RN > 1) ? $clog2(NUM_RN) : 1;
  localparam int CRD_W = chi_pkg::CREDIT_W;

  // Port with first claim this cycle
  logic [IDX_W-1:0]   prio;
  logic [IDX_W-1:0]   win;
  logic               win_found;
  logic               grant;
  // Credits held toward the SN
  logic [CRD_W-1:0]   sn_crd;
  logic               out_v;
  chi_pkg::req_flit_t out_flit;

  // --------------------
  // Round-robin pick
  // --------------------
  // Scan from prio upward, wrapping
  always_comb begin : rr_pick
    int unsigned k;
    win       = prio;
    win_found = 1'b0;
    for (int i = 0; i < NUM_RN; i++) begin
      k = (int'(prio) + i) % NUM_RN;
      if (!win_found && req_valid[k]) begin
        win       = IDX_W'(k);
        win_found = 1'b1;
      end
    end
  end

  // Output register clears every cycle, so only credits gate
  assign grant = win_found && (sn_crd != '0);

  always_comb begin
    for (int i = 0; i < NUM_RN; i++) begin
      req_ready[i] = grant && (win == IDX_W'(i));
    end
  end

  // --------------------
  // Credits and output
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      prio   <= '0;
      sn_crd <= '0;
      out_v  <= 1'b0;
    end else begin
      out_v  <= grant;
      sn_crd <= sn_crd + CRD_W'(sn_req.lcrdv) - CRD_W'(grant);
      // Move past the winner
      if (grant) begin
        prio <= (win == IDX_W'(NUM_RN - 1)) ? '0 : win + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      out_flit <= req_flit[win];
    end
  end

  // Single-cycle flitv per grant
  assign sn_req.flitv    = out_v;
  assign sn_req.flit     = out_flit;
  assign sn_req.flitpend = |req_valid;

  // SN never hands out credits past the counter limit
  a_sn_crd_max: assert property (@(posedge clk) disable iff (rst)
    (sn_req.lcrdv && !grant) |-> (int'(sn_crd) < chi_pkg::CREDIT_MAX));

endmodule

// ==== logic/chi_rn_port.sv ====
`timescale 1ns/1ps

module chi_rn_port #(
  parameter int                REQ_DEPTH = 4,
  parameter chi_pkg::node_id_t PORT_ID   = '0
) (
  input  logic               clk,
  input  logic               rst,
  chi_flit_if.rx             req_in,
  chi_flit_if.tx             rsp_out,
  input  logic               txlinkactivereq,
  output logic               txlinkactiveack,
  output chi_pkg::req_flit_t req_flit,
  output logic               req_valid,
  input  logic               req_ready,
  input  chi_pkg::rsp_flit_t rsp_flit,
  input  logic               rsp_valid,
  output logic               rsp_ready
);

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);
  localparam int CRD_W = chi_pkg::CREDIT_W;

  chi_pkg::link_state_t state;
  chi_pkg::link_state_t state_n;

  chi_pkg::req_flit_t req_mem [REQ_DEPTH];
  chi_pkg::req_flit_t stamped;
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   req_cnt;
  // Credits held by the RN, not yet used
  logic [CNT_W-1:0]   crd_out;
  logic               req_push;
  logic               req_pop;

  // Credits from the RN for its response channel
  logic [CRD_W-1:0]   rn_crd;
  logic               rsp_take;
  logic               rsp_flitv_q;
  chi_pkg::rsp_flit_t rsp_flit_q;

  // --------------------
  // Link activation
  // --------------------
  always_comb begin
    state_n = state;
    case (state)
      chi_pkg::LINK_STOP: begin
        if (txlinkactivereq) begin
          state_n = chi_pkg::LINK_ACTIVATE;
        end
      end
      chi_pkg::LINK_ACTIVATE: begin
        state_n = chi_pkg::LINK_RUN;
      end
      chi_pkg::LINK_RUN: begin
        if (!txlinkactivereq) begin
          state_n = chi_pkg::LINK_DEACTIVATE;
        end
      end
      chi_pkg::LINK_DEACTIVATE: begin
        // Wait for buffered flits to drain
        if (req_cnt == '0) begin
          state_n = chi_pkg::LINK_STOP;
        end
      end
      default: begin
        state_n = chi_pkg::LINK_STOP;
      end
    endcase
  end

  assign txlinkactiveack = (state == chi_pkg::LINK_RUN) ||
                           (state == chi_pkg::LINK_DEACTIVATE);

  // Grant while running and a slot is still unpromised
  assign req_in.lcrdv = (state == chi_pkg::LINK_RUN) &&
                        ((int'(crd_out) + int'(req_cnt)) < REQ_DEPTH);

  // --------------------
  // Request buffer
  // --------------------
  assign req_push = req_in.flitv;
  assign req_pop  = req_valid && req_ready;

  // Source id replaced by this port's id
  always_comb begin
    stamped = chi_pkg::req_flit_t'(req_in.flit);
    stamped[chi_pkg::REQ_SRCID_LSB +: chi_pkg::NODE_ID_W] = PORT_ID;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= chi_pkg::LINK_STOP;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      req_cnt <= '0;
      crd_out <= '0;
    end else begin
      state <= state_n;
      if (req_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (req_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      req_cnt <= req_cnt + CNT_W'(req_push) - CNT_W'(req_pop);
      crd_out <= crd_out + CNT_W'(req_in.lcrdv) - CNT_W'(req_push);
    end
  end

  always_ff @(posedge clk) begin
    if (req_push) begin
      req_mem[wr_ptr] <= stamped;
    end
  end

  // Head of buffer to the arbiter
  assign req_valid = (req_cnt != '0);
  assign req_flit  = req_mem[rd_ptr];

  // --------------------
  // Response delivery
  // --------------------
  // Take one response per RN credit
  assign rsp_ready = (rn_crd != '0);
  assign rsp_take  = rsp_valid && rsp_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rn_crd      <= '0;
      rsp_flitv_q <= 1'b0;
    end else begin
      rn_crd      <= rn_crd + CRD_W'(rsp_out.lcrdv) - CRD_W'(rsp_take);
      rsp_flitv_q <= rsp_take;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_take) begin
      rsp_flit_q <= rsp_flit;
    end
  end

  assign rsp_out.flitpend = rsp_valid;
  assign rsp_out.flitv    = rsp_flitv_q;
  assign rsp_out.flit     = rsp_flit_q;

  // RN sends only against a credit granted earlier
  a_req_credit: assert property (@(posedge clk) disable iff (rst)
    req_in.flitv |-> (crd_out != '0));

  // Every accepted flit finds a free slot
  a_req_no_ovf: assert property (@(posedge clk) disable iff (rst)
    req_push |-> ((int'(req_cnt) < REQ_DEPTH) || req_pop));

endmodule

// ==== logic/chi_flit_if.sv ====
`timescale 1ns/1ps

// One credited flit channel
interface chi_flit_if #(
  parameter int FLIT_W = chi_pkg::REQ_FLIT_W
) ();

  // Flit coming next cycle
  logic              flitpend;
  // One cycle per flit, needs a held credit
  logic              flitv;
  logic [FLIT_W-1:0] flit;
  // Receiver returns one credit per pulse
  logic              lcrdv;

  // Sending side
  modport tx (
    output flitpend,
    output flitv,
    output flit,
    input  lcrdv
  );

  // Receiving side
  modport rx (
    input  flitpend,
    input  flitv,
    input  flit,
    output lcrdv
  );

endinterface

// ==== logic/chi_pkg.sv ====
package chi_pkg;

  // Field widths
  localparam int NODE_ID_W = 2;
  localparam int TXN_ID_W  = 8;
  localparam int OPCODE_W  = 4;
  localparam int ADDR_W    = 32;
  localparam int RESP_W    = 2;

  typedef logic [NODE_ID_W-1:0] node_id_t;
  typedef logic [TXN_ID_W-1:0]  txn_id_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [RESP_W-1:0]    resp_t;

  // --------------------
  // Request flit layout
  // --------------------
  // Address at the bottom, txn id on top
  localparam int REQ_ADDR_LSB   = 0;
  localparam int REQ_OPCODE_LSB = REQ_ADDR_LSB + ADDR_W;
  localparam int REQ_SRCID_LSB  = REQ_OPCODE_LSB + OPCODE_W;
  localparam int REQ_TXNID_LSB  = REQ_SRCID_LSB + NODE_ID_W;
  localparam int REQ_FLIT_W     = REQ_TXNID_LSB + TXN_ID_W;
  typedef logic [REQ_FLIT_W-1:0] req_flit_t;

  // --------------------
  // Response flit layout
  // --------------------
  // Target id on top, routes the flit back
  localparam int RSP_RESP_LSB   = 0;
  localparam int RSP_OPCODE_LSB = RSP_RESP_LSB + RESP_W;
  localparam int RSP_TXNID_LSB  = RSP_OPCODE_LSB + OPCODE_W;
  localparam int RSP_TGTID_LSB  = RSP_TXNID_LSB + TXN_ID_W;
  localparam int RSP_FLIT_W     = RSP_TGTID_LSB + NODE_ID_W;
  typedef logic [RSP_FLIT_W-1:0] rsp_flit_t;

  // RN link activation
  typedef enum logic [1:0] {
    LINK_STOP,
    LINK_ACTIVATE,
    LINK_RUN,
    LINK_DEACTIVATE
  } link_state_t;

  // Link credit counters
  localparam int CREDIT_MAX = 15;
  localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

endpackage
